// File: compile.f
hw/udp_tx_pkg.sv
hw/sync_fifo.sv
hw/udp_tx_ingress.sv
hw/arp_cache.sv
hw/udp_header_calc.sv
hw/udp_tx_framer.sv
hw/udp_tx_top.sv
test/udp_tx_tb.sv

// File: hw/arp_cache.sv
`timescale 1ns/10ps
`default_nettype none

module arp_cache (
  input  wire                              mac_clk,
  input  wire                              arp_wr_en,
  input  wire [udp_tx_pkg::arp_addr_w-1:0] arp_wr_addr,
  input  wire [udp_tx_pkg::mac_w-1:0]      arp_wr_data,
  input  wire [udp_tx_pkg::ip_w-1:0]       dest_ip,
  input  wire [udp_tx_pkg::ip_w-1:0]       local_ip,
  input  wire [udp_tx_pkg::arp_addr_w-1:0] local_gateway,
  output logic [udp_tx_pkg::mac_w-1:0]     dest_mac
);

  import udp_tx_pkg::*;

  logic [mac_w-1:0]      arp_mem [2**arp_addr_w];
  logic [arp_addr_w-1:0] rd_addr;
  logic                  off_subnet;

  // Class C style subnet match on the upper three bytes
  assign off_subnet = (dest_ip[ip_w-1:8] != local_ip[ip_w-1:8]);
  assign rd_addr    = off_subnet ? local_gateway : dest_ip[arp_addr_w-1:0];

  always_ff @(posedge mac_clk) begin
    if (arp_wr_en) begin
      arp_mem[arp_wr_addr] <= arp_wr_data;
    end
    dest_mac <= arp_mem[rd_addr];
  end

endmodule

`default_nettype wire

// File: hw/sync_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sync_fifo #(
  parameter int width       = 64,
  parameter int depth       = 512,
  parameter int afull_level = 448
) (
  input  wire               mac_clk,
  input  wire               app_rst,
  input  wire               wr_en,
  input  wire [width-1:0]   din,
  input  wire               rd_en,
  output logic [width-1:0]  dout,
  output logic              empty,
  output logic              afull,
  output logic              overflow
);

  logic [width-1:0]           mem [depth];
  logic [$clog2(depth)-1:0]   wr_ptr;
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;
  logic                       full;
  logic                       do_wr;
  logic                       do_rd;

  assign full  = (count == depth);
  assign empty = (count == 0);
  // Threshold on occupancy, not on a full flag
  assign afull = (count >= afull_level);

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      // Write into a full buffer is dropped
      overflow <= wr_en && full;
      if (do_wr) begin
        wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
    // Popped word appears on the next cycle
    if (do_rd) begin
      dout <= mem[rd_ptr];
    end
  end

endmodule

`default_nettype wire

// File: hw/udp_header_calc.sv
`timescale 1ns/10ps
`default_nettype none

module udp_header_calc (
  input  wire                          mac_clk,
  input  wire                          app_rst,
  input  wire [udp_tx_pkg::size_w-1:0] frame_words,
  input  wire [udp_tx_pkg::ip_w-1:0]   dest_ip,
  input  wire [udp_tx_pkg::ip_w-1:0]   local_ip,
  output logic [15:0]                  ip_length,
  output logic [15:0]                  udp_length,
  output logic [15:0]                  ip_checksum
);

  import udp_tx_pkg::*;

  logic [15:0] byte_count;
  logic [17:0] fixed_0;
  logic [16:0] fixed_1;
  logic [15:0] csum_fixed;
  logic [17:0] sum_a;
  logic [17:0] sum_b;
  logic [16:0] fold_1;
  logic [15:0] fold_2;

  // Eight bytes per payload word
  assign byte_count = {frame_words[size_w-4:0], 3'b000};

  // Header words that do not change from frame to frame
  assign fixed_0    = 18'(ip_csum_const) + 18'(local_ip[31:16]) + 18'(local_ip[15:0]);
  assign fixed_1    = 17'(fixed_0[15:0]) + 17'(fixed_0[17:16]);
  assign csum_fixed = fixed_1[15:0] + 16'(fixed_1[16]);

  // Two end-around carry folds
  assign fold_1 = 17'(sum_b[15:0]) + 17'(sum_b[17:16]);
  assign fold_2 = fold_1[15:0] + 16'(fold_1[16]);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      ip_length   <= '0;
      udp_length  <= '0;
      sum_a       <= '0;
      sum_b       <= '0;
      ip_checksum <= '0;
    end else begin
      ip_length   <= byte_count + 16'(ip_len_extra);
      udp_length  <= byte_count + 16'(udp_len_extra);
      sum_a       <= 18'(csum_fixed) + 18'(dest_ip[31:16]) + 18'(dest_ip[15:0]);
      // Length joins once it is registered
      sum_b       <= sum_a + 18'(ip_length);
      ip_checksum <= ~fold_2;
    end
  end

endmodule

`default_nettype wire

// File: hw/udp_tx_framer.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_framer (
  input  wire                           mac_clk,
  input  wire                           app_rst,
  input  wire                           local_enable,
  input  wire [udp_tx_pkg::mac_w-1:0]   local_mac,
  input  wire [udp_tx_pkg::ip_w-1:0]    local_ip,
  input  wire [udp_tx_pkg::port_w-1:0]  local_port,
  input  wire udp_tx_pkg::ctrl_word_u   ctrl_head,
  input  wire                           ctrl_empty,
  input  wire                           overflow,
  input  wire [udp_tx_pkg::data_w-1:0]  data_head,
  input  wire [udp_tx_pkg::mac_w-1:0]   dest_mac,
  input  wire [15:0]                    ip_length,
  input  wire [15:0]                    udp_length,
  input  wire [15:0]                    ip_checksum,
  input  wire                           mac_tx_ack,
  output logic                          data_rd,
  output logic                          ctrl_rd,
  output logic [udp_tx_pkg::data_w-1:0] mac_tx_data,
  output logic [udp_tx_pkg::keep_w-1:0] mac_tx_data_valid,
  output logic                          mac_tx_start
);

  import udp_tx_pkg::*;

  tx_state_e         state;
  logic [size_w-1:0] words_left;
  logic [15:0]       leftover;
  logic              can_send;
  logic              more_words;
  logic [data_w-1:0] beat_be;

  // Big-endian byte string to MAC lane order, first byte in bits 7:0
  function automatic logic [data_w-1:0] wire_order(input logic [data_w-1:0] be);
    logic [data_w-1:0] w;
    for (int i = 0; i < keep_w; i++) begin
      w[8*i +: 8] = be[data_w-1-8*i -: 8];
    end
    return w;
  endfunction

  assign can_send   = !ctrl_empty && local_enable && !overflow;
  assign more_words = (words_left != '0);

  assign mac_tx_start = (state == idle) && can_send;
  assign ctrl_rd      = (state == last);
  // First pop in hdr5 so word 0 is at the head in hdr6
  assign data_rd      = (state == hdr5) || ((state == hdr6 || state == data) && more_words);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      state      <= idle;
      words_left <= '0;
    end else begin
      unique case (state)
        idle: begin
          if (can_send) begin
            state      <= hdr1;
            words_left <= ctrl_head.fields.size - 1'b1;
          end
        end
        hdr1: begin
          if (mac_tx_ack) begin
            state <= hdr2;
          end
        end
        hdr2: state <= hdr3;
        hdr3: state <= hdr4;
        hdr4: state <= hdr5;
        hdr5: state <= hdr6;
        hdr6, data: begin
          if (more_words) begin
            words_left <= words_left - 1'b1;
            state      <= data;
          end else begin
            state <= last;
          end
        end
        last: state <= idle;
        default: state <= idle;
      endcase
    end
  end

  // Low two bytes of each word spill into the next beat
  always_ff @(posedge mac_clk) begin
    leftover <= data_head[15:0];
  end

  always_comb begin
    beat_be           = '0;
    mac_tx_data_valid = '0;
    case (state)
      hdr1: begin
        beat_be           = {dest_mac, local_mac[47:32]};
        mac_tx_data_valid = '1;
      end
      hdr2: begin
        // Ethertype, then version/IHL and TOS
        beat_be           = {local_mac[31:0], eth_type_ipv4, ip_ver_ihl, 8'h00};
        mac_tx_data_valid = '1;
      end
      hdr3: begin
        beat_be           = {ip_length, 16'h0000, ip_flags, 8'h00, ip_ttl, ip_proto_udp};
        mac_tx_data_valid = '1;
      end
      hdr4: begin
        beat_be           = {ip_checksum, local_ip, ctrl_head.fields.ip[31:16]};
        mac_tx_data_valid = '1;
      end
      hdr5: begin
        beat_be           = {ctrl_head.fields.ip[15:0], local_port, ctrl_head.fields.port,
                             udp_length};
        mac_tx_data_valid = '1;
      end
      hdr6: begin
        // UDP checksum left at zero
        beat_be           = {16'h0000, data_head[63:16]};
        mac_tx_data_valid = '1;
      end
      data: begin
        beat_be           = {leftover, data_head[63:16]};
        mac_tx_data_valid = '1;
      end
      last: begin
        beat_be           = {leftover, 48'h0};
        mac_tx_data_valid = last_keep;
      end
      default: begin
        beat_be           = '0;
        mac_tx_data_valid = '0;
      end
    endcase
  end

  assign mac_tx_data = wire_order(beat_be);

endmodule

`default_nettype wire

// File: hw/udp_tx_ingress.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_ingress (
  input  wire                              mac_clk,
  input  wire                              app_rst,
  input  wire                              app_tx_valid,
  input  wire                              app_tx_end_of_frame,
  input  wire [udp_tx_pkg::data_w-1:0]     app_tx_data,
  input  wire [udp_tx_pkg::ip_w-1:0]       app_tx_dest_ip,
  input  wire [udp_tx_pkg::port_w-1:0]     app_tx_dest_port,
  input  wire                              data_rd,
  input  wire                              ctrl_rd,
  output logic [udp_tx_pkg::data_w-1:0]    data_head,
  output udp_tx_pkg::ctrl_word_u           ctrl_head,
  output logic                             ctrl_empty,
  output logic                             app_tx_afull,
  output logic                             overflow
);

  import udp_tx_pkg::*;

  logic              valid_q;
  logic              ctrl_wr;
  logic [data_w-1:0] data_q;
  logic [ip_w-1:0]   dest_ip_q;
  logic [port_w-1:0] dest_port_q;
  logic [size_w-1:0] word_count;
  ctrl_word_u        ctrl_din;

  logic data_afull;
  logic data_ovf;
  logic ctrl_afull;
  logic ctrl_ovf;
  logic ctrl_fifo_empty;
  logic ctrl_fifo_rd;
  logic head_valid;

  // Payload and destination registers
  always_ff @(posedge mac_clk) begin
    data_q      <= app_tx_data;
    dest_ip_q   <= app_tx_dest_ip;
    dest_port_q <= app_tx_dest_port;
  end

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      valid_q    <= 1'b0;
      ctrl_wr    <= 1'b0;
      word_count <= size_w'(1);
      overflow   <= 1'b0;
    end else begin
      valid_q <= app_tx_valid;
      ctrl_wr <= app_tx_valid && app_tx_end_of_frame;
      // Count already includes the word being registered
      if (ctrl_wr) begin
        word_count <= size_w'(1);
      end else if (valid_q) begin
        word_count <= word_count + 1'b1;
      end
      // Sticky until reset
      if (data_ovf || ctrl_ovf) begin
        overflow <= 1'b1;
      end
    end
  end

  always_comb begin
    ctrl_din.fields.size = word_count;
    ctrl_din.fields.port = dest_port_q;
    ctrl_din.fields.ip   = dest_ip_q;
  end

  sync_fifo #(
    .width       (data_w),
    .depth       (data_fifo_depth),
    .afull_level (data_afull_level)
  ) data_fifo_i (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (valid_q),
    .din      (data_q),
    .rd_en    (data_rd),
    .dout     (data_head),
    .empty    (),
    .afull    (data_afull),
    .overflow (data_ovf)
  );

  // Keep the head control entry loaded ahead of the framer
  assign ctrl_fifo_rd = !ctrl_fifo_empty && (!head_valid || ctrl_rd);

  always_ff @(posedge mac_clk) begin
    if (app_rst) begin
      head_valid <= 1'b0;
    end else if (ctrl_fifo_rd) begin
      head_valid <= 1'b1;
    end else if (ctrl_rd) begin
      head_valid <= 1'b0;
    end
  end

  assign ctrl_empty = !head_valid;

  sync_fifo #(
    .width       (data_w),
    .depth       (ctrl_fifo_depth),
    .afull_level (ctrl_afull_level)
  ) ctrl_fifo_i (
    .mac_clk  (mac_clk),
    .app_rst  (app_rst),
    .wr_en    (ctrl_wr),
    .din      (ctrl_din.raw),
    .rd_en    (ctrl_fifo_rd),
    .dout     (ctrl_head.raw),
    .empty    (ctrl_fifo_empty),
    .afull    (ctrl_afull),
    .overflow (ctrl_ovf)
  );

  assign app_tx_afull = data_afull || ctrl_afull;

endmodule

`default_nettype wire

// File: hw/udp_tx_pkg.sv
`default_nettype none

package udp_tx_pkg;

  // Datapath and field widths
  localparam int data_w     = 64;
  localparam int mac_w      = 48;
  localparam int ip_w       = 32;
  localparam int port_w     = 16;
  localparam int size_w     = 16;
  localparam int arp_addr_w = 8;
  localparam int keep_w     = 8;

  // Buffer sizing, in entries
  localparam int data_fifo_depth  = 512;
  localparam int ctrl_fifo_depth  = 16;
  localparam int data_afull_level = 448;
  localparam int ctrl_afull_level = 12;

  // Fixed Ethernet, IPv4 and UDP header fields
  localparam logic [15:0] eth_type_ipv4 = 16'h0800;
  localparam logic [7:0]  ip_ver_ihl    = 8'h45;
  localparam logic [7:0]  ip_flags      = 8'h40;
  localparam logic [7:0]  ip_ttl        = 8'hff;
  localparam logic [7:0]  ip_proto_udp  = 8'h11;

  // Ones-complement sum of 4500, 4000 and ff11
  localparam logic [15:0] ip_csum_const = 16'h8412;

  // IP header plus UDP header, and UDP header alone
  localparam int ip_len_extra  = 28;
  localparam int udp_len_extra = 8;

  // Final beat carries the two leftover payload bytes
  localparam logic [keep_w-1:0] last_keep = 8'b0000_0011;

  // One control FIFO entry per frame
  typedef union packed {
    logic [data_w-1:0] raw;
    struct packed {
      logic [size_w-1:0] size;
      logic [port_w-1:0] port;
      logic [ip_w-1:0]   ip;
    } fields;
  } ctrl_word_u;

  typedef enum logic [3:0] {
    idle,
    hdr1,
    hdr2,
    hdr3,
    hdr4,
    hdr5,
    hdr6,
    data,
    last
  } tx_state_e;

endpackage

`default_nettype wire

// File: hw/udp_tx_top.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_top (
  input  wire                              mac_clk,
  input  wire                              app_rst,
  input  wire                              local_enable,
  input  wire [udp_tx_pkg::mac_w-1:0]      local_mac,
  input  wire [udp_tx_pkg::ip_w-1:0]       local_ip,
  input  wire [udp_tx_pkg::port_w-1:0]     local_port,
  input  wire [udp_tx_pkg::arp_addr_w-1:0] local_gateway,
  input  wire                              arp_wr_en,
  input  wire [udp_tx_pkg::arp_addr_w-1:0] arp_wr_addr,
  input  wire [udp_tx_pkg::mac_w-1:0]      arp_wr_data,
  input  wire                              app_tx_valid,
  input  wire                              app_tx_end_of_frame,
  input  wire [udp_tx_pkg::data_w-1:0]     app_tx_data,
  input  wire [udp_tx_pkg::ip_w-1:0]       app_tx_dest_ip,
  input  wire [udp_tx_pkg::port_w-1:0]     app_tx_dest_port,
  output logic                             app_tx_afull,
  output logic                             app_tx_overflow,
  output logic [udp_tx_pkg::data_w-1:0]    mac_tx_data,
  output logic [udp_tx_pkg::keep_w-1:0]    mac_tx_data_valid,
  output logic                             mac_tx_start,
  input  wire                              mac_tx_ack
);

  import udp_tx_pkg::*;

  logic [data_w-1:0] data_head;
  ctrl_word_u        ctrl_head;
  logic              ctrl_empty;
  logic              data_rd;
  logic              ctrl_rd;
  logic [mac_w-1:0]  dest_mac;
  logic [15:0]       ip_length;
  logic [15:0]       udp_length;
  logic [15:0]       ip_checksum;

  udp_tx_ingress ingress_i (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .data_rd             (data_rd),
    .ctrl_rd             (ctrl_rd),
    .data_head           (data_head),
    .ctrl_head           (ctrl_head),
    .ctrl_empty          (ctrl_empty),
    .app_tx_afull        (app_tx_afull),
    .overflow            (app_tx_overflow)
  );

  arp_cache arp_i (
    .mac_clk       (mac_clk),
    .arp_wr_en     (arp_wr_en),
    .arp_wr_addr   (arp_wr_addr),
    .arp_wr_data   (arp_wr_data),
    .dest_ip       (ctrl_head.fields.ip),
    .local_ip      (local_ip),
    .local_gateway (local_gateway),
    .dest_mac      (dest_mac)
  );

  udp_header_calc calc_i (
    .mac_clk     (mac_clk),
    .app_rst     (app_rst),
    .frame_words (ctrl_head.fields.size),
    .dest_ip     (ctrl_head.fields.ip),
    .local_ip    (local_ip),
    .ip_length   (ip_length),
    .udp_length  (udp_length),
    .ip_checksum (ip_checksum)
  );

  udp_tx_framer framer_i (
    .mac_clk           (mac_clk),
    .app_rst           (app_rst),
    .local_enable      (local_enable),
    .local_mac         (local_mac),
    .local_ip          (local_ip),
    .local_port        (local_port),
    .ctrl_head         (ctrl_head),
    .ctrl_empty        (ctrl_empty),
    .overflow          (app_tx_overflow),
    .data_head         (data_head),
    .dest_mac          (dest_mac),
    .ip_length         (ip_length),
    .udp_length        (udp_length),
    .ip_checksum       (ip_checksum),
    .mac_tx_ack        (mac_tx_ack),
    .data_rd           (data_rd),
    .ctrl_rd           (ctrl_rd),
    .mac_tx_data       (mac_tx_data),
    .mac_tx_data_valid (mac_tx_data_valid),
    .mac_tx_start      (mac_tx_start)
  );

endmodule

`default_nettype wire

// File: test/udp_tx_tb.sv
`timescale 1ns/10ps
`default_nettype none

module udp_tx_tb;

  import udp_tx_pkg::*;

  localparam int num_rows = 7;

  logic                  mac_clk = 1'b0;
  logic                  app_rst;
  logic                  local_enable;
  logic [mac_w-1:0]      local_mac;
  logic [ip_w-1:0]       local_ip;
  logic [port_w-1:0]     local_port;
  logic [arp_addr_w-1:0] local_gateway;
  logic                  arp_wr_en;
  logic [arp_addr_w-1:0] arp_wr_addr;
  logic [mac_w-1:0]      arp_wr_data;
  logic                  app_tx_valid;
  logic                  app_tx_end_of_frame;
  logic [data_w-1:0]     app_tx_data;
  logic [ip_w-1:0]       app_tx_dest_ip;
  logic [port_w-1:0]     app_tx_dest_port;
  logic                  app_tx_afull;
  logic                  app_tx_overflow;
  logic [data_w-1:0]     mac_tx_data;
  logic [keep_w-1:0]     mac_tx_data_valid;
  logic                  mac_tx_start;
  logic                  mac_tx_ack;

  // Frame table
  string       row_name   [num_rows];
  logic [31:0] row_ip     [num_rows];
  logic [15:0] row_port   [num_rows];
  int          row_words  [num_rows];
  logic        row_enable [num_rows];
  // Held frames stay buffered and leave with the next unheld row
  logic        row_hold   [num_rows];

  logic [7:0]  exp_bytes [$];
  int          exp_words [$];
  string       exp_name  [$];
  logic [7:0]  rx_bytes  [$];
  logic [31:0] lfsr = 32'h15942052;

  udp_tx_top dut_i (
    .mac_clk             (mac_clk),
    .app_rst             (app_rst),
    .local_enable        (local_enable),
    .local_mac           (local_mac),
    .local_ip            (local_ip),
    .local_port          (local_port),
    .local_gateway       (local_gateway),
    .arp_wr_en           (arp_wr_en),
    .arp_wr_addr         (arp_wr_addr),
    .arp_wr_data         (arp_wr_data),
    .app_tx_valid        (app_tx_valid),
    .app_tx_end_of_frame (app_tx_end_of_frame),
    .app_tx_data         (app_tx_data),
    .app_tx_dest_ip      (app_tx_dest_ip),
    .app_tx_dest_port    (app_tx_dest_port),
    .app_tx_afull        (app_tx_afull),
    .app_tx_overflow     (app_tx_overflow),
    .mac_tx_data         (mac_tx_data),
    .mac_tx_data_valid   (mac_tx_data_valid),
    .mac_tx_start        (mac_tx_start),
    .mac_tx_ack          (mac_tx_ack)
  );

  always #20 mac_clk = ~mac_clk;

  task automatic fail_value(input string test, input string what, input logic [63:0] exp,
                            input logic [63:0] act);
    $display("ERR %s: %s expected %0h actual %0h", test, what, exp, act);
    $display("Errors found");
    $fatal(1, "value check failed");
  endtask

  task automatic fail_msg(input string text);
    $display("%s", text);
    $display("Errors found");
    $fatal(1, "check failed");
  endtask

  // Right-shift Galois form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] next_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      w    = {w[62:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return w;
  endfunction

  function automatic logic [47:0] arp_value(input logic [7:0] idx);
    return {8'h02, 8'h5e, idx, ~idx, idx ^ 8'ha5, idx + 8'h31};
  endfunction

  // Off-subnet destinations go through the gateway entry
  function automatic logic [7:0] arp_index(input logic [31:0] ip);
    return (ip[31:8] != local_ip[31:8]) ? local_gateway : ip[7:0];
  endfunction

  function automatic logic [15:0] header_checksum(input logic [15:0] len,
                                                  input logic [31:0] src,
                                                  input logic [31:0] dst);
    logic [31:0] sum;
    sum = 32'h4500 + 32'(len) + 32'h4000 + 32'hff11 + 32'(src[31:16]) + 32'(src[15:0])
        + 32'(dst[31:16]) + 32'(dst[15:0]);
    while (sum[31:16] != 16'h0000) begin
      sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
  endfunction

  task automatic set_row(input int r, input string name, input logic [31:0] ip,
                         input logic [15:0] port, input int words, input logic en,
                         input logic hold);
    row_name[r]   = name;
    row_ip[r]     = ip;
    row_port[r]   = port;
    row_words[r]  = words;
    row_enable[r] = en;
    row_hold[r]   = hold;
  endtask

  task automatic load_table();
    set_row(0, "on_subnet_n1",  32'hc0a8_0a21, 16'h1388, 1, 1'b1, 1'b0);
    set_row(1, "off_subnet_n2", 32'h0a00_0007, 16'h0035, 2, 1'b1, 1'b0);
    set_row(2, "on_subnet_n7",  32'hc0a8_0ac8, 16'h2710, 7, 1'b1, 1'b0);
    set_row(3, "enable_gate",   32'hc0a8_0a33, 16'h0101, 3, 1'b0, 1'b0);
    set_row(4, "burst_a",       32'hc0a8_0a40, 16'h4000, 4, 1'b0, 1'b1);
    set_row(5, "burst_b",       32'h0808_0808, 16'h4001, 1, 1'b0, 1'b1);
    set_row(6, "burst_c",       32'hc0a8_0a41, 16'h4002, 5, 1'b0, 1'b0);
  endtask

  task automatic load_arp();
    for (int i = 0; i < 256; i++) begin
      @(posedge mac_clk);
      arp_wr_en   <= 1'b1;
      arp_wr_addr <= 8'(i);
      arp_wr_data <= arp_value(8'(i));
    end
    @(posedge mac_clk);
    arp_wr_en <= 1'b0;
  endtask

  // Big-endian, most significant byte first on the wire
  task automatic push_bytes(input logic [63:0] v, input int count);
    for (int b = count - 1; b >= 0; b--) begin
      exp_bytes.push_back(v[8*b +: 8]);
    end
  endtask

  task automatic send_frame(input int r);
    logic [63:0] w;
    logic [15:0] ip_len;
    int          n;
    n      = row_words[r];
    ip_len = 16'(8 * n + 28);
    push_bytes(arp_value(arp_index(row_ip[r])), 6);
    push_bytes(local_mac, 6);
    push_bytes(16'h0800, 2);
    push_bytes(16'h4500, 2);
    push_bytes(ip_len, 2);
    push_bytes(16'h0000, 2);
    push_bytes(16'h4000, 2);
    push_bytes(16'hff11, 2);
    push_bytes(header_checksum(ip_len, local_ip, row_ip[r]), 2);
    push_bytes(local_ip, 4);
    push_bytes(row_ip[r], 4);
    push_bytes(local_port, 2);
    push_bytes(row_port[r], 2);
    push_bytes(16'(8 * n + 8), 2);
    push_bytes(16'h0000, 2);
    exp_words.push_back(n);
    exp_name.push_back(row_name[r]);
    for (int k = 0; k < n; k++) begin
      w = next_word();
      push_bytes(w, 8);
      @(posedge mac_clk);
      app_tx_valid        <= 1'b1;
      app_tx_end_of_frame <= (k == n - 1);
      app_tx_data         <= w;
      app_tx_dest_ip      <= row_ip[r];
      app_tx_dest_port    <= row_port[r];
    end
    @(posedge mac_clk);
    app_tx_valid        <= 1'b0;
    app_tx_end_of_frame <= 1'b0;
  endtask

  // Lane 0 is the first wire byte
  task automatic capture_beat();
    for (int i = 0; i < 8; i++) begin
      if (mac_tx_data_valid[i]) begin
        rx_bytes.push_back(mac_tx_data[8*i +: 8]);
      end
    end
  endtask

  task automatic receive_frame();
    string      name;
    int         n;
    int         wait_cycles;
    int         beats;
    logic       done;
    logic [7:0] exp;
    name        = exp_name.pop_front();
    n           = exp_words.pop_front();
    wait_cycles = 0;
    rx_bytes.delete();
    @(negedge mac_clk);
    while (mac_tx_start !== 1'b1) begin
      assert (mac_tx_data_valid === 8'h00)
        else fail_value(name, "idle valid mask", 64'h0, 64'(mac_tx_data_valid));
      wait_cycles++;
      assert (wait_cycles < 200)
        else fail_msg($sformatf("%s: timeout waiting for mac_tx_start", name));
      @(negedge mac_clk);
    end
    // Framer enters hdr1 on this edge
    @(posedge mac_clk);
    // Ack one cycle late so hdr1 is held
    @(posedge mac_clk);
    mac_tx_ack <= 1'b1;
    @(negedge mac_clk);
    assert (mac_tx_data_valid === 8'hff)
      else fail_value(name, "hdr1 valid mask", 64'hff, 64'(mac_tx_data_valid));
    capture_beat();
    @(posedge mac_clk);
    mac_tx_ack <= 1'b0;
    beats = 1;
    done  = 1'b0;
    while (!done) begin
      @(negedge mac_clk);
      beats++;
      assert (beats <= n + 6)
        else fail_msg($sformatf("%s: frame did not end after %0d beats", name, n + 6));
      if (mac_tx_data_valid === 8'b0000_0011) begin
        done = 1'b1;
      end else begin
        assert (mac_tx_data_valid === 8'hff)
          else fail_value(name, "beat valid mask", 64'hff, 64'(mac_tx_data_valid));
      end
      capture_beat();
    end
    assert (beats == n + 6) else fail_value(name, "beats", 64'(n + 6), 64'(beats));
    assert (rx_bytes.size() == 42 + 8 * n)
      else fail_value(name, "frame bytes", 64'(42 + 8 * n), 64'(rx_bytes.size()));
    for (int k = 0; k < rx_bytes.size(); k++) begin
      exp = exp_bytes.pop_front();
      assert (rx_bytes[k] === exp)
        else fail_value(name, $sformatf("byte %0d", k), 64'(exp), 64'(rx_bytes[k]));
    end
  endtask

  task automatic check_start_held(input string name);
    for (int c = 0; c < 30; c++) begin
      @(negedge mac_clk);
      assert (mac_tx_start === 1'b0)
        else fail_value(name, "mac_tx_start while disabled", 64'h0, 64'(mac_tx_start));
    end
  endtask

  task automatic run_row(input int r);
    @(posedge mac_clk);
    local_enable <= row_enable[r];
    send_frame(r);
    if (!row_hold[r]) begin
      if (!row_enable[r]) begin
        check_start_held(row_name[r]);
        @(posedge mac_clk);
        local_enable <= 1'b1;
      end
      while (exp_words.size() > 0) begin
        receive_frame();
      end
    end
  endtask

  task automatic overflow_test();
    int afull_at;
    int ovf_at;
    int wait_cycles;
    afull_at    = -1;
    ovf_at      = -1;
    wait_cycles = 0;
    @(posedge mac_clk);
    local_enable <= 1'b0;
    // One oversized frame, nothing drains while disabled
    for (int k = 0; k < 520; k++) begin
      @(posedge mac_clk);
      app_tx_valid        <= 1'b1;
      app_tx_end_of_frame <= (k == 519);
      app_tx_data         <= {2{32'(k)}};
      app_tx_dest_ip      <= 32'hc0a8_0a50;
      app_tx_dest_port    <= 16'h5000;
      @(negedge mac_clk);
      if (afull_at < 0 && app_tx_afull === 1'b1) begin
        afull_at = k;
      end
      if (ovf_at < 0 && app_tx_overflow === 1'b1) begin
        ovf_at = k;
      end
    end
    @(posedge mac_clk);
    app_tx_valid        <= 1'b0;
    app_tx_end_of_frame <= 1'b0;
    @(negedge mac_clk);
    while (app_tx_overflow !== 1'b1) begin
      wait_cycles++;
      assert (wait_cycles < 20) else fail_msg("overflow: app_tx_overflow never went high");
      @(negedge mac_clk);
    end
    if (ovf_at < 0) begin
      ovf_at = 520;
    end
    assert (afull_at >= 0 && afull_at < ovf_at)
      else fail_msg("overflow: app_tx_afull did not rise before app_tx_overflow");
    @(posedge mac_clk);
    local_enable <= 1'b1;
    for (int c = 0; c < 40; c++) begin
      @(negedge mac_clk);
      assert (app_tx_overflow === 1'b1)
        else fail_value("overflow", "sticky app_tx_overflow", 64'h1, 64'(app_tx_overflow));
      assert (mac_tx_start === 1'b0)
        else fail_value("overflow", "mac_tx_start after overflow", 64'h0, 64'(mac_tx_start));
    end
  endtask

  initial begin
    app_rst             = 1'b1;
    local_enable        = 1'b0;
    local_mac           = 48'h02_11_22_33_44_55;
    local_ip            = 32'hc0a8_0a05;
    local_port          = 16'h1f90;
    local_gateway       = 8'h01;
    arp_wr_en           = 1'b0;
    arp_wr_addr         = '0;
    arp_wr_data         = '0;
    app_tx_valid        = 1'b0;
    app_tx_end_of_frame = 1'b0;
    app_tx_data         = '0;
    app_tx_dest_ip      = '0;
    app_tx_dest_port    = '0;
    mac_tx_ack          = 1'b0;
    load_table();
    repeat (8) @(posedge mac_clk);
    app_rst <= 1'b0;
    @(negedge mac_clk);
    assert (mac_tx_start === 1'b0)
      else fail_value("reset", "mac_tx_start", 64'h0, 64'(mac_tx_start));
    assert (mac_tx_data_valid === 8'h00)
      else fail_value("reset", "mac_tx_data_valid", 64'h0, 64'(mac_tx_data_valid));
    assert (app_tx_overflow === 1'b0)
      else fail_value("reset", "app_tx_overflow", 64'h0, 64'(app_tx_overflow));
    assert (app_tx_afull === 1'b0)
      else fail_value("reset", "app_tx_afull", 64'h0, 64'(app_tx_afull));
    load_arp();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    overflow_test();
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
